// ==== source/cu_macros.svh ====
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// State register encoding
`define CU_STATE_W 5

// RV32I major opcode field, instr[6:0]
`define CU_OPCODE_W 7

// ALU operand selects and write-back select
`define CU_SEL_W 3

`define CU_ADDR_SEL_W 2
`define CU_ALUOP_W 2

`endif

// ==== source/cu_pkg.sv ====
`default_nettype none

`include "cu_macros.svh"

package cu_pkg;

    typedef enum logic [`CU_STATE_W-1:0] {
        ST_FETCH,
        ST_FETCH_VALIDATE,
        ST_DECODE,
        ST_MEM_ADDR,
        ST_MEM_READ,
        ST_MEM_WB,
        ST_MEM_WRITE,
        ST_EXECUTE_R,
        ST_EXECUTE_I,
        ST_ALU_WB,
        ST_JAL,
        ST_BRANCH,
        ST_JALR_PC,
        ST_JALR,
        ST_AUIPC,
        ST_LUI,
        ST_EXECUTE_MDU,
        ST_MDU_WAIT,
        ST_MDU_WB
    } cu_state_e;

    typedef enum logic [`CU_OPCODE_W-1:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011 // CSR and environment calls, not supported
    } opcode_e;

    typedef enum logic [3:0] {
        CLS_LOAD,
        CLS_STORE,
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_MDU,
        CLS_JAL,
        CLS_BRANCH,
        CLS_JALR,
        CLS_AUIPC,
        CLS_LUI,
        CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [`CU_SEL_W-1:0] {
        SRC_A_PC     = 3'b000,
        SRC_A_RS1    = 3'b001,
        SRC_A_OLD_PC = 3'b010, // PC of the instruction in flight
        SRC_A_ZERO   = 3'b011
    } alu_src_a_e;

    typedef enum logic [`CU_SEL_W-1:0] {
        SRC_B_RS2  = 3'b000,
        SRC_B_FOUR = 3'b001,
        SRC_B_IMM  = 3'b010
    } alu_src_b_e;

    typedef enum logic [`CU_SEL_W-1:0] {
        WB_ALU = 3'b000,
        WB_MEM = 3'b001,
        WB_MDU = 3'b111
    } wb_sel_e;

    typedef enum logic [`CU_ALUOP_W-1:0] {
        ALU_ADD    = 2'b00,
        ALU_BRANCH = 2'b01,
        ALU_FUNCT  = 2'b10 // ALU control looks at func3/func7
    } alu_op_e;

    // Memory address source
    localparam logic [`CU_ADDR_SEL_W-1:0] ADDR_PC    = 2'b00;
    localparam logic [`CU_ADDR_SEL_W-1:0] ADDR_SAVED = 2'b10;

    typedef struct packed {
        opcode_e opcode;
        logic    func7_lsb; // Set for MUL/DIV in the OP space
    } instr_fields_t;

    typedef struct packed {
        logic                      pc_write;
        logic                      pc_write_cond;
        logic                      ir_write;
        logic                      pc_source;
        logic                      reg_write;
        logic                      is_immediate;
        logic                      save_address;
        alu_src_a_e                alu_src_a;
        alu_src_b_e                alu_src_b;
        alu_op_e                   alu_op;
        wb_sel_e                   wb_sel;
        logic [`CU_ADDR_SEL_W-1:0] addr_sel;
    } datapath_ctrl_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== source/opcode_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module opcode_decoder
    import cu_pkg::*;
(
    input  instr_fields_t instr,
    output instr_class_e  instr_class
);

    always_comb begin
        case (instr.opcode)
            OPC_LOAD: instr_class = CLS_LOAD;
            OPC_STORE: instr_class = CLS_STORE;
            OPC_OP: begin
                if (instr.func7_lsb) begin // M extension shares the OP opcode
                    instr_class = CLS_MDU;
                end else begin
                    instr_class = CLS_ALU_REG;
                end
            end
            OPC_OP_IMM: instr_class = CLS_ALU_IMM;
            OPC_JAL: instr_class = CLS_JAL;
            OPC_BRANCH: instr_class = CLS_BRANCH;
            OPC_JALR: instr_class = CLS_JALR;
            OPC_AUIPC: instr_class = CLS_AUIPC;
            OPC_LUI: instr_class = CLS_LUI;
            OPC_SYSTEM: instr_class = CLS_ILLEGAL; // No CSR support
            default: instr_class = CLS_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/state_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module state_sequencer
    import cu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_e instr_class,
    input  logic         wb_ack,
    input  logic         mdu_done,
    output cu_state_e    state
);

    cu_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = ST_FETCH;
        case (state)
            ST_FETCH: begin
                if (wb_ack) begin
                    next_state = ST_FETCH_VALIDATE;
                end else begin
                    next_state = ST_FETCH; // Wait for memory
                end
            end
            ST_FETCH_VALIDATE: next_state = ST_DECODE;
            ST_DECODE: begin
                case (instr_class)
                    CLS_LOAD: next_state = ST_MEM_ADDR;
                    CLS_STORE: next_state = ST_MEM_ADDR;
                    CLS_ALU_REG: next_state = ST_EXECUTE_R;
                    CLS_ALU_IMM: next_state = ST_EXECUTE_I;
                    CLS_MDU: next_state = ST_EXECUTE_MDU;
                    CLS_JAL: next_state = ST_JAL;
                    CLS_BRANCH: next_state = ST_BRANCH;
                    CLS_JALR: next_state = ST_JALR_PC;
                    CLS_AUIPC: next_state = ST_AUIPC;
                    CLS_LUI: next_state = ST_LUI;
                    CLS_ILLEGAL: next_state = ST_FETCH; // Skip the instruction
                    default: next_state = ST_FETCH;
                endcase
            end
            ST_MEM_ADDR: begin
                if (instr_class == CLS_LOAD) begin
                    next_state = ST_MEM_READ;
                end else begin
                    next_state = ST_MEM_WRITE;
                end
            end
            ST_MEM_READ: begin
                if (wb_ack) begin
                    next_state = ST_MEM_WB;
                end else begin
                    next_state = ST_MEM_READ;
                end
            end
            ST_MEM_WB: next_state = ST_FETCH;
            ST_MEM_WRITE: begin
                if (wb_ack) begin
                    next_state = ST_FETCH;
                end else begin
                    next_state = ST_MEM_WRITE;
                end
            end
            ST_EXECUTE_R: next_state = ST_ALU_WB;
            ST_EXECUTE_I: next_state = ST_ALU_WB;
            ST_ALU_WB: next_state = ST_FETCH;
            ST_JAL: next_state = ST_ALU_WB; // Link register write
            ST_BRANCH: next_state = ST_FETCH;
            ST_JALR_PC: next_state = ST_JALR;
            ST_JALR: next_state = ST_ALU_WB;
            ST_AUIPC: next_state = ST_ALU_WB;
            ST_LUI: next_state = ST_ALU_WB;
            ST_EXECUTE_MDU: next_state = ST_MDU_WAIT;
            ST_MDU_WAIT: begin
                if (mdu_done) begin
                    next_state = ST_MDU_WB;
                end else begin
                    next_state = ST_MDU_WAIT;
                end
            end
            ST_MDU_WB: next_state = ST_FETCH;
            default: next_state = ST_FETCH;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module control_decoder
    import cu_pkg::*;
(
    input  cu_state_e      state,
    output datapath_ctrl_t ctrl,
    output wb_req_t        wb_req,
    output logic           mdu_start
);

    always_comb begin
        ctrl.pc_write      = 1'b0;
        ctrl.pc_write_cond = 1'b0;
        ctrl.ir_write      = 1'b0;
        ctrl.pc_source     = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.is_immediate  = 1'b0;
        ctrl.save_address  = 1'b0;
        ctrl.alu_src_a     = SRC_A_PC;
        ctrl.alu_src_b     = SRC_B_RS2;
        ctrl.alu_op        = ALU_ADD;
        ctrl.wb_sel        = WB_ALU;
        ctrl.addr_sel      = ADDR_PC;
        wb_req.cyc         = 1'b0;
        wb_req.stb         = 1'b0;
        wb_req.we          = 1'b0;
        mdu_start          = 1'b0;

        case (state)
            ST_FETCH: begin
                wb_req.cyc = 1'b1;
                wb_req.stb = 1'b1;
            end
            ST_FETCH_VALIDATE: begin
                ctrl.ir_write  = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.alu_src_b = SRC_B_FOUR; // PC + 4
            end
            ST_DECODE: begin
                // Branch target precomputed here
                ctrl.alu_src_a = SRC_A_OLD_PC;
                ctrl.alu_src_b = SRC_B_IMM;
            end
            ST_MEM_ADDR: begin
                ctrl.alu_src_a    = SRC_A_RS1;
                ctrl.alu_src_b    = SRC_B_IMM;
                ctrl.save_address = 1'b1;
            end
            ST_MEM_READ: begin
                wb_req.cyc    = 1'b1;
                wb_req.stb    = 1'b1;
                ctrl.addr_sel = ADDR_SAVED;
            end
            ST_MEM_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM;
            end
            ST_MEM_WRITE: begin
                wb_req.cyc    = 1'b1;
                wb_req.stb    = 1'b1;
                wb_req.we     = 1'b1;
                ctrl.addr_sel = ADDR_SAVED;
            end
            ST_EXECUTE_R: begin
                ctrl.alu_src_a = SRC_A_RS1;
                ctrl.alu_op    = ALU_FUNCT;
            end
            ST_EXECUTE_I: begin
                ctrl.alu_src_a    = SRC_A_RS1;
                ctrl.alu_src_b    = SRC_B_IMM;
                ctrl.alu_op       = ALU_FUNCT;
                ctrl.is_immediate = 1'b1;
            end
            ST_ALU_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ALU;
            end
            ST_JAL: begin
                ctrl.alu_src_a = SRC_A_OLD_PC; // Link value old PC + 4
                ctrl.alu_src_b = SRC_B_FOUR;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            ST_BRANCH: begin
                ctrl.alu_src_a     = SRC_A_RS1;
                ctrl.alu_op        = ALU_BRANCH;
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source     = 1'b1;
            end
            ST_JALR_PC: begin
                ctrl.alu_src_a = SRC_A_RS1; // rs1 + imm target
                ctrl.alu_src_b = SRC_B_IMM;
            end
            ST_JALR: begin
                ctrl.alu_src_a    = SRC_A_OLD_PC;
                ctrl.alu_src_b    = SRC_B_FOUR;
                ctrl.pc_write     = 1'b1;
                ctrl.pc_source    = 1'b1;
                ctrl.is_immediate = 1'b1;
            end
            ST_AUIPC: begin
                ctrl.alu_src_a = SRC_A_OLD_PC;
                ctrl.alu_src_b = SRC_B_IMM;
            end
            ST_LUI: begin
                ctrl.alu_src_a = SRC_A_ZERO;
                ctrl.alu_src_b = SRC_B_IMM;
            end
            ST_EXECUTE_MDU: begin
                ctrl.alu_src_a = SRC_A_RS1;
                mdu_start      = 1'b1; // Single-cycle pulse
            end
            ST_MDU_WAIT: begin
                ctrl.alu_src_a = SRC_A_RS1; // Operands held for the MDU
            end
            ST_MDU_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MDU;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module control_unit
    import cu_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  instr_fields_t  instr,
    input  logic           wb_ack,
    input  logic           mdu_done,
    output datapath_ctrl_t ctrl,
    output wb_req_t        wb_req,
    output logic           mdu_start
);

    instr_class_e instr_class;
    cu_state_e    state;

    opcode_decoder opcode_decoder_inst (
        .instr       (instr),
        .instr_class (instr_class)
    );

    state_sequencer state_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .wb_ack      (wb_ack),
        .mdu_done    (mdu_done),
        .state       (state)
    );

    // Moore outputs, decoded from the state only
    control_decoder control_decoder_inst (
        .state     (state),
        .ctrl      (ctrl),
        .wb_req    (wb_req),
        .mdu_start (mdu_start)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/control_unit_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module control_unit_checker
    import cu_pkg::*;
(
    input logic           clk,
    input logic           reset,
    input instr_fields_t  instr,
    input logic           wb_ack,
    input logic           mdu_done,
    input datapath_ctrl_t ctrl,
    input wb_req_t        wb_req,
    input logic           mdu_start
);

    int fail_count = 0;

    logic fetch_ack;
    logic data_read_ack;
    logic is_alu_like;
    logic is_jump;

    task automatic flag_failure(input string msg);
        $error("%s", msg);
        fail_count++;
    endtask

    assign fetch_ack = wb_req.stb && wb_ack && (ctrl.addr_sel == ADDR_PC);
    assign data_read_ack = wb_req.stb && wb_ack && !wb_req.we &&
                           (ctrl.addr_sel == ADDR_SAVED);
    assign is_alu_like = (instr.opcode == OPC_OP && !instr.func7_lsb) ||
                         instr.opcode == OPC_OP_IMM || instr.opcode == OPC_LUI ||
                         instr.opcode == OPC_AUIPC;
    assign is_jump = instr.opcode == OPC_JAL || instr.opcode == OPC_JALR;

    // Enables stay quiet in reset
    assert property (@(posedge clk) reset |-> !ctrl.reg_write && !ctrl.pc_write &&
            !ctrl.pc_write_cond && !ctrl.ir_write && !ctrl.save_address && !mdu_start &&
            !wb_req.we)
        else flag_failure("control enable active during reset");

    assert property (@(posedge clk) disable iff (reset)
            wb_req.stb && !wb_ack |=> wb_req.cyc && wb_req.stb && $stable(wb_req.we))
        else flag_failure("bus request dropped or changed before ack");

    assert property (@(posedge clk) disable iff (reset)
            wb_req.stb && wb_ack && !wb_req.we |=> !wb_req.stb)
        else flag_failure("read request not dropped after ack");

    // Store returns straight to fetch
    assert property (@(posedge clk) disable iff (reset)
            wb_req.stb && wb_ack && wb_req.we |=> wb_req.stb && !wb_req.we)
        else flag_failure("no fetch request after store ack");

    assert property (@(posedge clk) disable iff (reset)
            fetch_ack |=> ctrl.ir_write && ctrl.pc_write)
        else flag_failure("ir_write or pc_write missing after fetch ack");

    assert property (@(posedge clk) disable iff (reset) ctrl.ir_write |-> $past(fetch_ack))
        else flag_failure("ir_write without a fetch ack");

    assert property (@(posedge clk) disable iff (reset)
            ctrl.pc_write && !ctrl.ir_write |-> is_jump)
        else flag_failure("pc_write outside fetch and jumps");

    assert property (@(posedge clk) disable iff (reset) ctrl.ir_write && is_alu_like
            |=> !ctrl.reg_write ##1 !ctrl.reg_write ##1 ctrl.reg_write && ctrl.wb_sel == WB_ALU)
        else flag_failure("ALU write-back not three cycles after ir_write");

    assert property (@(posedge clk) disable iff (reset)
            ctrl.ir_write && instr.opcode == OPC_BRANCH
            |=> !ctrl.pc_write_cond ##1 ctrl.pc_write_cond)
        else flag_failure("branch pc_write_cond not two cycles after ir_write");

    assert property (@(posedge clk) disable iff (reset) ctrl.ir_write && instr.opcode == OPC_LOAD
            |-> ##2 ctrl.save_address ##1 wb_req.stb && !wb_req.we &&
            ctrl.addr_sel == ADDR_SAVED)
        else flag_failure("load address save or read request missing");

    assert property (@(posedge clk) disable iff (reset)
            data_read_ack |=> ctrl.reg_write && ctrl.wb_sel == WB_MEM)
        else flag_failure("load write-back missing after data ack");

    assert property (@(posedge clk) disable iff (reset)
            ctrl.ir_write && instr.opcode == OPC_STORE
            |-> ##2 ctrl.save_address ##1 wb_req.stb && wb_req.we)
        else flag_failure("store address save or write request missing");

    assert property (@(posedge clk) disable iff (reset)
            ctrl.ir_write && instr.opcode == OPC_OP && instr.func7_lsb |-> ##2 mdu_start)
        else flag_failure("mdu_start not two cycles after ir_write");

    assert property (@(posedge clk) disable iff (reset)
            mdu_done |=> ctrl.reg_write && ctrl.wb_sel == WB_MDU)
        else flag_failure("MDU write-back missing after mdu_done");

    assert property (@(posedge clk) disable iff (reset) ctrl.ir_write && instr.opcode == OPC_SYSTEM
            |=> !ctrl.reg_write ##1 !ctrl.reg_write && wb_req.stb && !wb_req.we)
        else flag_failure("illegal opcode did not return to fetch");

endmodule

bind control_unit control_unit_checker checker_inst (.*);

`default_nettype wire

// ==== sim/control_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module control_unit_tb
    import cu_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000; // 21 instructions, long waits, wide margin

    logic           clk;
    logic           reset;
    instr_fields_t  instr;
    logic           wb_ack;
    logic           mdu_done;
    datapath_ctrl_t ctrl;
    wb_req_t        wb_req;
    logic           mdu_start;

    instr_fields_t program_q[$];
    int            prog_idx = 0;
    int            ir_count = 0;
    int            cycle_count = 0;
    int            mismatch_count = 0;
    logic          finished = 1'b0;
    logic          slave_busy;
    int            slave_wait;
    int            mdu_cnt;

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .reset(reset));

    control_unit control_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .wb_ack    (wb_ack),
        .mdu_done  (mdu_done),
        .ctrl      (ctrl),
        .wb_req    (wb_req),
        .mdu_start (mdu_start)
    );

    function automatic instr_fields_t make_instr(opcode_e op, logic f7);
        instr_fields_t f;
        f.opcode    = op;
        f.func7_lsb = f7;
        return f;
    endfunction

    task automatic build_program();
        opcode_e       ops[10];
        logic          f7s[10];
        instr_fields_t tmp;
        int            j;
        ops = '{OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_OP,
                OPC_JAL, OPC_BRANCH, OPC_JALR, OPC_AUIPC, OPC_LUI};
        f7s = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < 10; k++) begin
                program_q.push_back(make_instr(ops[k], f7s[k]));
            end
        end
        program_q.push_back(make_instr(OPC_SYSTEM, 1'b0));
        for (int i = program_q.size() - 1; i > 0; i--) begin // Fisher-Yates
            j = $urandom_range(i, 0);
            tmp = program_q[i];
            program_q[i] = program_q[j];
            program_q[j] = tmp;
        end
    endtask

    // Instruction register model, loads on the fetch ack
    always @(posedge clk) begin
        if (!reset && wb_req.stb && wb_ack && ctrl.addr_sel == ADDR_PC) begin
            if (prog_idx < program_q.size()) begin
                instr <= program_q[prog_idx];
                prog_idx <= prog_idx + 1;
            end else begin
                finished <= 1'b1;
            end
        end
        if (!reset && ctrl.ir_write) begin
            ir_count <= ir_count + 1;
        end
    end

    // Wishbone slave, one ack after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (reset) begin
            wb_ack     <= 1'b0;
            slave_busy <= 1'b0;
            slave_wait <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (slave_busy) begin
            if (slave_wait == 0) begin
                wb_ack     <= 1'b1;
                slave_busy <= 1'b0;
            end else begin
                slave_wait <= slave_wait - 1;
            end
        end else if (wb_req.stb) begin
            slave_wait <= $urandom_range(3, 0);
            slave_busy <= 1'b1;
        end
    end

    // MDU model
    always @(posedge clk) begin
        if (reset) begin
            mdu_done <= 1'b0;
            mdu_cnt  <= 0;
        end else begin
            mdu_done <= 1'b0;
            if (mdu_start) begin
                mdu_cnt <= $urandom_range(5, 1);
            end else if (mdu_cnt != 0) begin
                if (mdu_cnt == 1) begin
                    mdu_done <= 1'b1;
                end
                mdu_cnt <= mdu_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run hung after %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        instr    = make_instr(OPC_SYSTEM, 1'b0);
        wb_ack   = 1'b0;
        mdu_done = 1'b0;
        void'($urandom(32'h8403_56d9));
        build_program();
        wait (finished);
        @(negedge clk);
        if (ir_count != program_q.size()) begin
            $display("mismatch instr_count expected %0d actual %0d",
                     program_q.size(), ir_count);
            mismatch_count++;
        end
        $display("Assertion failures: %0d, mismatches: %0d",
                 control_unit_inst.checker_inst.fail_count, mismatch_count);
        if (control_unit_inst.checker_inst.fail_count == 0 && mismatch_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/cu_pkg.sv
source/opcode_decoder.sv
source/state_sequencer.sv
source/control_decoder.sv
source/control_unit.sv
sim/tb_clock_gen.sv
sim/control_unit_checker.sv
sim/control_unit_tb.sv
